// File: verilog/mem_pkg.sv
package mem_pkg;

	//////////////////////////////////////////////////////////////////////
	// memory bus widths
	//////////////////////////////////////////////////////////////////////

	// byte address
	localparam int ADDR_W = 32;

	// response and return tag, zero means no response
	localparam int TAG_W = 4;

	// number of distinct tag values
	localparam int NUM_TAGS = 16;

	// one cache line is one memory transfer
	localparam int LINE_BYTES = 8;

	//////////////////////////////////////////////////////////////////////
	// bus command and access size
	//////////////////////////////////////////////////////////////////////

	// command on the memory bus
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_command_t;

	// size of a processor data access
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'h0,
		SIZE_HALF = 2'h1,
		SIZE_WORD = 2'h2
	} mem_size_t;

	//////////////////////////////////////////////////////////////////////
	// cache line
	//////////////////////////////////////////////////////////////////////

	// one memory word seen four ways
	// element 0 is always the lowest address
	typedef union packed {
		// whole line as moved on the bus
		logic [LINE_BYTES*8-1:0] dword;
		// instruction words, picked by address bit 2
		logic [1:0][31:0] words;
		// half words, picked by address bits 2..1
		logic [3:0][15:0] halves;
		// bytes, picked by address bits 2..0
		logic [7:0][7:0] bytes;
	} mem_line_t;

endpackage

// File: verilog/line_lane.sv
`timescale 1ns/1ps

module line_lane import mem_pkg::*; (
	input  mem_line_t   line,
	input  logic [2:0]  offset,
	input  mem_size_t   size,
	input  logic        is_unsigned,
	input  logic [31:0] wdata,
	output logic [31:0] load_value,
	output mem_line_t   merged_line
);

	// lanes addressed by the offset
	logic [7:0]  sel_byte;
	logic [15:0] sel_half;
	logic [31:0] sel_word;

	assign sel_byte = line.bytes[offset];
	// low offset bit ignored, halves are aligned
	assign sel_half = line.halves[offset[2:1]];
	assign sel_word = line.words[offset[2]];

	always_comb begin
		// untouched lanes pass through
		merged_line = line;
		case (size)
			SIZE_BYTE: begin
				// sign bit only when signed
				load_value = {{24{~is_unsigned & sel_byte[7]}}, sel_byte};
				merged_line.bytes[offset] = wdata[7:0];
			end
			SIZE_HALF: begin
				load_value = {{16{~is_unsigned & sel_half[15]}}, sel_half};
				merged_line.halves[offset[2:1]] = wdata[15:0];
			end
			default: begin
				// full word, nothing to extend
				load_value = sel_word;
				merged_line.words[offset[2]] = wdata;
			end
		endcase
	end

endmodule

// File: verilog/icache.sv
`timescale 1ns/1ps

module icache import mem_pkg::*; #(
	parameter int ICACHE_LINES = 32
) (
	input  logic              clock,
	input  logic              reset,
	input  logic [ADDR_W-1:0] fetch_addr,
	output logic [31:0]       fetch_inst,
	output logic              fetch_valid,
	output bus_command_t      mem_command,
	output logic [ADDR_W-1:0] mem_addr,
	input  logic [TAG_W-1:0]  mem_response,
	input  logic [TAG_W-1:0]  mem_tag,
	input  mem_line_t         mem_data
);

	localparam int OFF_W = $clog2(LINE_BYTES);
	localparam int IDX_W = $clog2(ICACHE_LINES);
	localparam int TAG_BITS = ADDR_W - OFF_W - IDX_W;

	// miss engine states
	localparam logic [1:0] IC_IDLE = 2'd0;
	localparam logic [1:0] IC_REQ  = 2'd1;
	localparam logic [1:0] IC_WAIT = 2'd2;
	localparam logic [1:0] IC_FILL = 2'd3;

	logic [1:0]            state;
	logic [TAG_W-1:0]      wait_tag;
	mem_line_t             fill_line;

	// line storage
	logic [TAG_BITS-1:0]   tags [ICACHE_LINES];
	mem_line_t             data [ICACHE_LINES];
	logic [ICACHE_LINES-1:0] valid;

	logic [IDX_W-1:0]      index;
	logic [TAG_BITS-1:0]   addr_tag;
	logic                  hit;

	//////////////////////////////////////////////////////////////////////
	// lookup
	//////////////////////////////////////////////////////////////////////

	assign index    = fetch_addr[OFF_W +: IDX_W];
	assign addr_tag = fetch_addr[ADDR_W-1 -: TAG_BITS];
	assign hit      = valid[index] && (tags[index] == addr_tag);

	// same cycle as the address
	assign fetch_valid = hit;
	assign fetch_inst  = data[index].words[fetch_addr[2]];

	//////////////////////////////////////////////////////////////////////
	// miss engine
	//////////////////////////////////////////////////////////////////////

	// request held until memory gives a tag
	assign mem_command = (state == IC_REQ) ? BUS_LOAD : BUS_NONE;
	assign mem_addr    = {fetch_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= IC_IDLE;
			wait_tag <= '0;
			valid    <= '0;
		end else begin
			case (state)
				IC_IDLE: begin
					if (!hit)
						state <= IC_REQ;
				end
				IC_REQ: begin
					// zero response, try again next cycle
					if (mem_response != '0) begin
						wait_tag <= mem_response;
						state    <= IC_WAIT;
					end
				end
				IC_WAIT: begin
					if (mem_tag == wait_tag)
						state <= IC_FILL;
				end
				default: begin
					// fill_line goes in, hit shows next cycle
					valid[index] <= 1'b1;
					state        <= IC_IDLE;
				end
			endcase
		end
	end

	// returned line and array writes
	always_ff @(posedge clock) begin
		if (state == IC_WAIT && mem_tag == wait_tag)
			fill_line <= mem_data;
		if (state == IC_FILL) begin
			data[index] <= fill_line;
			tags[index] <= addr_tag;
		end
	end

endmodule

// File: verilog/dcache.sv
`timescale 1ns/1ps

module dcache import mem_pkg::*; #(
	parameter int DCACHE_LINES = 32
) (
	input  logic              clock,
	input  logic              reset,
	input  bus_command_t      dc_command,
	input  logic [ADDR_W-1:0] dc_addr,
	input  mem_size_t         dc_size,
	input  logic              dc_unsigned,
	input  logic [31:0]       dc_wdata,
	output logic [31:0]       dc_rdata,
	output logic              dc_done,
	output bus_command_t      mem_command,
	output logic [ADDR_W-1:0] mem_addr,
	output mem_line_t         mem_wdata,
	input  logic [TAG_W-1:0]  mem_response,
	input  logic [TAG_W-1:0]  mem_tag,
	input  mem_line_t         mem_data
);

	localparam int OFF_W = $clog2(LINE_BYTES);
	localparam int IDX_W = $clog2(DCACHE_LINES);
	localparam int TAG_BITS = ADDR_W - OFF_W - IDX_W;

	// access sequencer states
	localparam logic [2:0] ST_IDLE       = 3'd0;
	localparam logic [2:0] ST_LOOKUP     = 3'd1;
	localparam logic [2:0] ST_FILL_REQ   = 3'd2;
	localparam logic [2:0] ST_FILL_WAIT  = 3'd3;
	localparam logic [2:0] ST_WRITE_THRU = 3'd4;

	logic [2:0]              state;
	logic [TAG_W-1:0]        wait_tag;

	logic [TAG_BITS-1:0]     tags [DCACHE_LINES];
	mem_line_t               data [DCACHE_LINES];
	logic [DCACHE_LINES-1:0] valid;

	logic [IDX_W-1:0]        index;
	logic [TAG_BITS-1:0]     addr_tag;
	logic                    hit;
	logic                    is_store;
	logic                    fill_done;
	logic                    store_hit;
	mem_line_t               cur_line;
	mem_line_t               merged_line;

	//////////////////////////////////////////////////////////////////////
	// lookup and lane select
	//////////////////////////////////////////////////////////////////////

	assign index    = dc_addr[OFF_W +: IDX_W];
	assign addr_tag = dc_addr[ADDR_W-1 -: TAG_BITS];
	assign hit      = valid[index] && (tags[index] == addr_tag);
	assign is_store = (dc_command == BUS_STORE);
	assign cur_line = data[index];

	// matching tag back from memory
	assign fill_done = (state == ST_FILL_WAIT) && (mem_tag == wait_tag);
	assign store_hit = (state == ST_LOOKUP) && hit && is_store;

	line_lane lane (
		.line        (cur_line),
		.offset      (dc_addr[2:0]),
		.size        (dc_size),
		.is_unsigned (dc_unsigned),
		.wdata       (dc_wdata),
		.load_value  (dc_rdata),
		.merged_line (merged_line)
	);

	//////////////////////////////////////////////////////////////////////
	// bus side
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (state)
			ST_FILL_REQ:   mem_command = BUS_LOAD;
			ST_WRITE_THRU: mem_command = BUS_STORE;
			default:       mem_command = BUS_NONE;
		endcase
	end

	assign mem_addr = {dc_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
	// array already holds the merged line during write-through
	assign mem_wdata = cur_line;

	// load hit in lookup, store on acceptance
	assign dc_done = ((state == ST_LOOKUP) && hit && !is_store) ||
		((state == ST_WRITE_THRU) && (mem_response != '0));

	//////////////////////////////////////////////////////////////////////
	// sequencer
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state    <= ST_IDLE;
			wait_tag <= '0;
			valid    <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (dc_command != BUS_NONE)
						state <= ST_LOOKUP;
				end
				ST_LOOKUP: begin
					// stores also need the line first
					if (!hit)
						state <= ST_FILL_REQ;
					else if (is_store)
						state <= ST_WRITE_THRU;
					else
						state <= ST_IDLE;
				end
				ST_FILL_REQ: begin
					if (mem_response != '0) begin
						wait_tag <= mem_response;
						state    <= ST_FILL_WAIT;
					end
				end
				ST_FILL_WAIT: begin
					// back to lookup, finishes as a hit
					if (fill_done) begin
						valid[index] <= 1'b1;
						state        <= ST_LOOKUP;
					end
				end
				ST_WRITE_THRU: begin
					if (mem_response != '0)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// array writes, fill or store merge
	always_ff @(posedge clock) begin
		if (fill_done) begin
			data[index] <= mem_data;
			tags[index] <= addr_tag;
		end else if (store_hit) begin
			data[index] <= merged_line;
		end
	end

endmodule

// File: verilog/cache_controller.sv
`timescale 1ns/1ps

module cache_controller import mem_pkg::*; (
	input  logic              clock,
	input  logic              reset,
	// icache side
	input  bus_command_t      ic_command,
	input  logic [ADDR_W-1:0] ic_addr,
	output logic [TAG_W-1:0]  ic_response,
	output logic [TAG_W-1:0]  ic_tag,
	// dcache side
	input  bus_command_t      dc_command,
	input  logic [ADDR_W-1:0] dc_addr,
	input  mem_line_t         dc_wdata,
	output logic [TAG_W-1:0]  dc_response,
	output logic [TAG_W-1:0]  dc_tag,
	// returned line, shared by both caches
	output mem_line_t         line_data,
	// memory bus
	output bus_command_t      mem_command,
	output logic [ADDR_W-1:0] mem_addr,
	output mem_line_t         mem_wdata,
	input  logic [TAG_W-1:0]  mem_response,
	input  logic [TAG_W-1:0]  mem_tag,
	input  mem_line_t         mem_data
);

	logic                dc_active;
	logic                ic_active;
	logic                load_accepted;
	logic                tag_returned;

	// owner table, one entry per tag value
	logic [NUM_TAGS-1:0] owner_valid;
	logic [NUM_TAGS-1:0] owner_is_dc;

	//////////////////////////////////////////////////////////////////////
	// request arbitration
	//////////////////////////////////////////////////////////////////////

	// dcache wins, icache sees zero and retries
	assign dc_active = (dc_command != BUS_NONE);
	assign ic_active = !dc_active && (ic_command != BUS_NONE);

	assign mem_command = dc_active ? dc_command : ic_command;
	assign mem_addr    = dc_active ? dc_addr : ic_addr;
	// only the dcache ever stores
	assign mem_wdata   = dc_wdata;

	assign dc_response = dc_active ? mem_response : '0;
	assign ic_response = ic_active ? mem_response : '0;

	//////////////////////////////////////////////////////////////////////
	// tag routing
	//////////////////////////////////////////////////////////////////////

	assign load_accepted = (mem_command == BUS_LOAD) && (mem_response != '0);
	assign tag_returned  = (mem_tag != '0) && owner_valid[mem_tag];

	assign dc_tag = (tag_returned && owner_is_dc[mem_tag]) ? mem_tag : '0;
	assign ic_tag = (tag_returned && !owner_is_dc[mem_tag]) ? mem_tag : '0;

	assign line_data = mem_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			owner_valid <= '0;
			owner_is_dc <= '0;
		end else begin
			// free on return
			if (tag_returned)
				owner_valid[mem_tag] <= 1'b0;
			// a new claim on the same tag takes over
			if (load_accepted) begin
				owner_valid[mem_response] <= 1'b1;
				owner_is_dc[mem_response] <= dc_active;
			end
		end
	end

endmodule

// File: verilog/memory_system.sv
`timescale 1ns/1ps

module memory_system import mem_pkg::*; #(
	parameter int ICACHE_LINES = 32,
	parameter int DCACHE_LINES = 32
) (
	input  logic              clock,
	input  logic              reset,
	// instruction fetch
	input  logic [ADDR_W-1:0] fetch_addr,
	output logic [31:0]       fetch_inst,
	output logic              fetch_valid,
	// data access
	input  bus_command_t      dc_command,
	input  logic [ADDR_W-1:0] dc_addr,
	input  mem_size_t         dc_size,
	input  logic              dc_unsigned,
	input  logic [31:0]       dc_wdata,
	output logic [31:0]       dc_rdata,
	output logic              dc_done,
	// memory bus
	output bus_command_t      mem_command,
	output logic [ADDR_W-1:0] mem_addr,
	output mem_line_t         mem_wdata,
	input  logic [TAG_W-1:0]  mem_response,
	input  mem_line_t         mem_data,
	input  logic [TAG_W-1:0]  mem_tag
);

	// icache to controller
	bus_command_t      ic_command;
	logic [ADDR_W-1:0] ic_addr;
	logic [TAG_W-1:0]  ic_response;
	logic [TAG_W-1:0]  ic_tag;

	// dcache to controller
	bus_command_t      dc_mem_command;
	logic [ADDR_W-1:0] dc_mem_addr;
	mem_line_t         dc_mem_wdata;
	logic [TAG_W-1:0]  dc_response;
	logic [TAG_W-1:0]  dc_tag;

	// returned line for both caches
	mem_line_t         line_data;

	//////////////////////////////////////////////////////////////////////
	// caches
	//////////////////////////////////////////////////////////////////////

	icache #(.ICACHE_LINES(ICACHE_LINES)) icache_0 (
		.clock        (clock),
		.reset        (reset),
		.fetch_addr   (fetch_addr),
		.fetch_inst   (fetch_inst),
		.fetch_valid  (fetch_valid),
		.mem_command  (ic_command),
		.mem_addr     (ic_addr),
		.mem_response (ic_response),
		.mem_tag      (ic_tag),
		.mem_data     (line_data)
	);

	dcache #(.DCACHE_LINES(DCACHE_LINES)) dcache_0 (
		.clock        (clock),
		.reset        (reset),
		.dc_command   (dc_command),
		.dc_addr      (dc_addr),
		.dc_size      (dc_size),
		.dc_unsigned  (dc_unsigned),
		.dc_wdata     (dc_wdata),
		.dc_rdata     (dc_rdata),
		.dc_done      (dc_done),
		.mem_command  (dc_mem_command),
		.mem_addr     (dc_mem_addr),
		.mem_wdata    (dc_mem_wdata),
		.mem_response (dc_response),
		.mem_tag      (dc_tag),
		.mem_data     (line_data)
	);

	//////////////////////////////////////////////////////////////////////
	// shared bus
	//////////////////////////////////////////////////////////////////////

	cache_controller cache_controller_0 (
		.clock        (clock),
		.reset        (reset),
		.ic_command   (ic_command),
		.ic_addr      (ic_addr),
		.ic_response  (ic_response),
		.ic_tag       (ic_tag),
		.dc_command   (dc_mem_command),
		.dc_addr      (dc_mem_addr),
		.dc_wdata     (dc_mem_wdata),
		.dc_response  (dc_response),
		.dc_tag       (dc_tag),
		.line_data    (line_data),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_response (mem_response),
		.mem_tag      (mem_tag),
		.mem_data     (mem_data)
	);

endmodule

// File: verification/memory_system_checker.sv
`timescale 1ns/1ps

module memory_system_checker import mem_pkg::*; (
	input logic              clock,
	input logic              reset,
	input bus_command_t      mem_command,
	input logic              dc_done,
	input logic [ADDR_W-1:0] mem_addr
);

	// bus quiet while in reset
	reset_quiet: assert property (@(posedge clock) reset |-> mem_command == BUS_NONE)
		else $error("memory command issued during reset");

	// completion is a single cycle pulse
	done_pulse: assert property (@(posedge clock) disable iff (reset) dc_done |=> !dc_done)
		else $error("dc_done held for two cycles");

	// whole lines only
	line_aligned: assert property (@(posedge clock) disable iff (reset)
		(mem_command != BUS_NONE) |-> (mem_addr[2:0] == 3'b000))
		else $error("memory address not line aligned");

endmodule

bind memory_system memory_system_checker checker_0 (
	.clock       (clock),
	.reset       (reset),
	.mem_command (mem_command),
	.dc_done     (dc_done),
	.mem_addr    (mem_addr)
);

// File: verification/memory_system_tb.sv
`timescale 1ns/1ps

module memory_system_tb import mem_pkg::*; ();

	localparam int MEM_LINES = 256;
	localparam int MAX_OPS = 64;

	logic              clock;
	logic              reset;
	logic [ADDR_W-1:0] fetch_addr;
	logic [31:0]       fetch_inst;
	logic              fetch_valid;
	bus_command_t      dc_command;
	logic [ADDR_W-1:0] dc_addr;
	mem_size_t         dc_size;
	logic              dc_unsigned;
	logic [31:0]       dc_wdata;
	logic [31:0]       dc_rdata;
	logic              dc_done;
	bus_command_t      mem_command;
	logic [ADDR_W-1:0] mem_addr;
	mem_line_t         mem_wdata;
	logic [TAG_W-1:0]  mem_response;
	mem_line_t         mem_data = '0;
	logic [TAG_W-1:0]  mem_tag = '0;

	//////////////////////////////////////////////////////////////////////
	// memory model state
	//////////////////////////////////////////////////////////////////////

	logic [63:0]       mem_model [MEM_LINES];
	logic              accept_now = 1'b0;
	logic [TAG_W-1:0]  next_tag = 4'd1;
	logic              took = 1'b0;
	bus_command_t      took_cmd;
	logic [ADDR_W-1:0] took_addr;
	logic [63:0]       took_wdata;
	int                due_q [$];
	logic [TAG_W-1:0]  tag_q [$];
	logic [63:0]       data_q [$];
	int                seed = 32'h4b51ef29;
	int                roll;
	int                cycle = 0;
	int                limit = 0;

	// golden operations
	logic [7:0]        op_kind [MAX_OPS];
	logic [31:0]       op_addr [MAX_OPS];
	logic [31:0]       op_size [MAX_OPS];
	logic [31:0]       op_flag [MAX_OPS];
	logic [31:0]       op_value [MAX_OPS];
	logic [31:0]       op_faddr [MAX_OPS];
	logic [31:0]       op_finst [MAX_OPS];
	int                num_ops = 0;

	int                pass_count = 0;
	int                error_count = 0;
	int                test_errors = 0;
	int                test_num = 0;

	memory_system #(.ICACHE_LINES(32), .DCACHE_LINES(32)) UUT (
		.clock        (clock),
		.reset        (reset),
		.fetch_addr   (fetch_addr),
		.fetch_inst   (fetch_inst),
		.fetch_valid  (fetch_valid),
		.dc_command   (dc_command),
		.dc_addr      (dc_addr),
		.dc_size      (dc_size),
		.dc_unsigned  (dc_unsigned),
		.dc_wdata     (dc_wdata),
		.dc_rdata     (dc_rdata),
		.dc_done      (dc_done),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_response (mem_response),
		.mem_data     (mem_data),
		.mem_tag      (mem_tag)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	//////////////////////////////////////////////////////////////////////
	// tagged memory model
	//////////////////////////////////////////////////////////////////////

	// accept decision fixed for the whole cycle
	assign mem_response = (mem_command != BUS_NONE && accept_now) ? next_tag : '0;

	// outputs settled by the falling edge
	always @(negedge clock) begin
		took       = !reset && (mem_command != BUS_NONE) && (mem_response != '0);
		took_cmd   = mem_command;
		took_addr  = mem_addr;
		took_wdata = mem_wdata;
	end

	always @(posedge clock) begin
		#1;
		cycle = cycle + 1;
		if (took) begin
			// only the low 2 KB are modeled
			if (took_addr[ADDR_W-1:11] != '0) begin
				$display("memory access at address %h is outside the modeled range", took_addr);
				error_count = error_count + 1;
				test_errors = test_errors + 1;
			end
			if (took_cmd == BUS_STORE) begin
				mem_model[took_addr[10:3]] = took_wdata;
			end else begin
				roll = $random(seed);
				// 3 to 6 cycles, kept in order
				due_q.push_back(cycle + 3 + (roll & 3));
				tag_q.push_back(next_tag);
				data_q.push_back(mem_model[took_addr[10:3]]);
			end
			next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
			took = 1'b0;
		end
		if (due_q.size() > 0 && cycle >= due_q[0]) begin
			void'(due_q.pop_front());
			mem_tag  = tag_q.pop_front();
			mem_data = data_q.pop_front();
		end else begin
			mem_tag  = '0;
			mem_data = '0;
		end
		roll = $random(seed);
		accept_now = roll[0];
	end

	// cycle limit
	always @(posedge clock) begin
		if (limit > 0 && cycle >= limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s expected %h got %h", name, expected, actual);
			error_count = error_count + 1;
			test_errors = test_errors + 1;
		end
	endtask

	task automatic end_test(input string desc);
		test_num = test_num + 1;
		if (test_errors == 0) begin
			pass_count = pass_count + 1;
			$display("[%0d] %s: ok", test_num, desc);
		end else begin
			$display("[%0d] %s: %0d mismatches", test_num, desc, test_errors);
		end
		test_errors = 0;
	endtask

	// store lanes replaced in a model line
	function automatic logic [63:0] merge_lanes(input logic [63:0] line,
		input logic [2:0] off, input logic [1:0] size, input logic [31:0] data);
		logic [63:0] result;
		int pos;
		result = line;
		pos = int'(off) * 8;
		if (size == 2'd0) begin
			result[pos +: 8] = data[7:0];
		end else if (size == 2'd1) begin
			pos = int'(off[2:1]) * 16;
			result[pos +: 16] = data[15:0];
		end else begin
			pos = int'(off[2]) * 32;
			result[pos +: 32] = data;
		end
		return result;
	endfunction

	task automatic read_golden();
		int fd;
		int code;
		logic [63:0] tok;
		logic [31:0] a;
		logic [63:0] d;
		string rest;
		fd = $fopen("verification/memory_system_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden data file");
			error_count = error_count + 1;
		end else begin
			while (!$feof(fd)) begin
				tok = '0;
				code = $fscanf(fd, "%s", tok);
				if (code == 1) begin
					if (tok[7:0] == "M") begin
						code = $fscanf(fd, "%h %h", a, d);
						mem_model[a[10:3]] = d;
					end else if (tok[7:0] == "#") begin
						code = $fgets(rest, fd);
					end else begin
						op_kind[num_ops] = tok[7:0];
						if (tok[7:0] == "F")
							code = $fscanf(fd, "%h %h", op_faddr[num_ops],
								op_finst[num_ops]);
						else if (tok[7:0] == "S")
							code = $fscanf(fd, "%h %h %h", op_addr[num_ops],
								op_size[num_ops], op_value[num_ops]);
						else if (tok[7:0] == "P")
							code = $fscanf(fd, "%h %h %h %h %h %h", op_faddr[num_ops],
								op_finst[num_ops], op_addr[num_ops], op_size[num_ops],
								op_flag[num_ops], op_value[num_ops]);
						else
							code = $fscanf(fd, "%h %h %h %h", op_addr[num_ops],
								op_size[num_ops], op_flag[num_ops], op_value[num_ops]);
						num_ops = num_ops + 1;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// hold the address until the line is present
	task automatic fetch_word(input logic [31:0] addr, output logic [31:0] inst);
		@(posedge clock);
		#1;
		fetch_addr = addr;
		@(negedge clock);
		while (!fetch_valid)
			@(negedge clock);
		inst = fetch_inst;
	endtask

	// one data request, held until dc_done
	task automatic data_access(input bus_command_t cmd, input logic [31:0] addr,
		input logic [31:0] size, input logic [31:0] flag, input logic [31:0] wdata,
		output logic [31:0] rdata, output int latency);
		@(posedge clock);
		#1;
		dc_command  = cmd;
		dc_addr     = addr;
		dc_size     = mem_size_t'(size[1:0]);
		dc_unsigned = flag[0];
		dc_wdata    = wdata;
		latency = 0;
		@(negedge clock);
		while (!dc_done) begin
			latency = latency + 1;
			@(negedge clock);
		end
		rdata = dc_rdata;
		@(posedge clock);
		#1;
		dc_command = BUS_NONE;
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : main
		logic [31:0] got_inst;
		logic [31:0] got_data;
		logic [63:0] expected_line;
		int lat;
		int i;
		int j;
		reset = 1'b1;
		fetch_addr = '0;
		dc_command = BUS_NONE;
		dc_addr = '0;
		dc_size = SIZE_WORD;
		dc_unsigned = 1'b0;
		dc_wdata = '0;
		// address-dependent fill for lines outside the image
		for (j = 0; j < MEM_LINES; j = j + 1)
			mem_model[j] = {32'(j) ^ 32'hc3a50000, 32'(j * 8)};
		read_golden();
		limit = num_ops * 40 + 200;
		repeat (16) @(posedge clock);
		#1;
		reset = 1'b0;

		// quiet after reset, only the boot fetch of line 0 may start
		repeat (4) begin
			@(negedge clock);
			compare_value("fetch_valid", 64'h0, 64'(fetch_valid));
			compare_value("dc_done", 64'h0, 64'(dc_done));
			if (mem_command != BUS_NONE &&
				(mem_command != BUS_LOAD || mem_addr != '0)) begin
				$display("unexpected memory command %0d at address %h after reset",
					mem_command, mem_addr);
				error_count = error_count + 1;
				test_errors = test_errors + 1;
			end
		end
		end_test("idle after reset");
		while (!fetch_valid)
			@(negedge clock);

		for (i = 0; i < num_ops; i = i + 1) begin
			if (op_kind[i] == "F") begin
				fetch_word(op_faddr[i], got_inst);
				compare_value("fetch_inst", 64'(op_finst[i]), 64'(got_inst));
				// away to line 0 and back, both must hit at once
				@(posedge clock);
				#1;
				fetch_addr = '0;
				@(negedge clock);
				compare_value("fetch_valid", 64'h1, 64'(fetch_valid));
				@(posedge clock);
				#1;
				fetch_addr = op_faddr[i];
				@(negedge clock);
				compare_value("fetch_valid", 64'h1, 64'(fetch_valid));
				compare_value("fetch_inst", 64'(op_finst[i]), 64'(fetch_inst));
				// a miss would put a load on the bus one cycle later
				@(negedge clock);
				compare_value("mem_command", 64'(BUS_NONE), 64'(mem_command));
				end_test($sformatf("fetch %h", op_faddr[i]));
			end else if (op_kind[i] == "L") begin
				data_access(BUS_LOAD, op_addr[i], op_size[i], op_flag[i], '0, got_data, lat);
				compare_value("dc_rdata", 64'(op_value[i]), 64'(got_data));
				// now resident
				data_access(BUS_LOAD, op_addr[i], op_size[i], op_flag[i], '0, got_data, lat);
				compare_value("dc_rdata", 64'(op_value[i]), 64'(got_data));
				compare_value("dc_done latency", 64'h1, 64'(lat));
				end_test($sformatf("load %h size %0d", op_addr[i], op_size[i]));
			end else if (op_kind[i] == "S") begin
				expected_line = merge_lanes(mem_model[op_addr[i][10:3]], op_addr[i][2:0],
					op_size[i][1:0], op_value[i]);
				data_access(BUS_STORE, op_addr[i], op_size[i], '0, op_value[i], got_data, lat);
				// model line written just after the accepting edge
				@(negedge clock);
				compare_value("mem_wdata", expected_line, mem_model[op_addr[i][10:3]]);
				end_test($sformatf("store %h size %0d", op_addr[i], op_size[i]));
			end else begin
				// both misses in flight together
				fork
					fetch_word(op_faddr[i], got_inst);
					data_access(BUS_LOAD, op_addr[i], op_size[i], op_flag[i], '0,
						got_data, lat);
				join
				compare_value("fetch_inst", 64'(op_finst[i]), 64'(got_inst));
				compare_value("dc_rdata", 64'(op_value[i]), 64'(got_data));
				end_test($sformatf("fetch %h with load %h", op_faddr[i], op_addr[i]));
			end
		end

		$display("tests passed: %0d, check errors: %0d", pass_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: verification/memory_system_golden.txt
# M line_addr dword | F addr inst | L addr size unsigned expected | S addr size data
# P fetch_addr inst load_addr size unsigned expected (size 0 byte, 1 half, 2 word)
M 00000040 00a0011300500093
M 00000048 40110233002081b3
M 00000050 fe000ee30000006f
M 00000400 12f0567892347f81
M 00000408 44332211ddccbbaa
M 00000410 0123456789abcdef
M 00000418 8000ffff7fff0001
F 00000040 00500093
F 00000044 00a00113
F 0000004c 40110233
L 00000400 0 0 ffffff81
L 00000400 0 1 00000081
L 00000401 0 0 0000007f
L 00000402 1 0 ffff9234
L 00000402 1 1 00009234
L 00000404 2 0 12f05678
L 00000406 1 0 000012f0
L 00000408 2 1 ddccbbaa
S 00000409 0 0000005a
L 00000408 2 0 ddcc5aaa
L 00000409 0 0 0000005a
L 0000040a 0 0 ffffffcc
S 0000040c 1 0000beef
L 0000040c 2 0 4433beef
L 0000040e 1 1 00004433
S 00000414 2 cafef00d
L 00000410 2 0 89abcdef
L 00000414 2 0 cafef00d
L 00000416 0 1 000000fe
P 00000050 0000006f 0000041c 2 0 8000ffff

// File: files.f
verilog/mem_pkg.sv
verilog/line_lane.sv
verilog/icache.sv
verilog/dcache.sv
verilog/cache_controller.sv
verilog/memory_system.sv
verification/memory_system_checker.sv
verification/memory_system_tb.sv

// File: run.sh
#!/bin/sh
# build and run the memory system testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module memory_system_tb \
	-f files.f \
	-o memory_system_sim

out=$(./obj_dir/memory_system_sim)
echo "$out"

if echo "$out" | grep -q "^TEST PASSED$"; then
	exit 0
fi
exit 1
